/* flist.f */
logic/chan_mem_pkg.sv
logic/apv_word_pkg.sv
logic/thr_ram.sv
logic/event_fifo.sv
logic/zero_suppressor.sv
logic/event_counter.sv
logic/channel_processor.sv
verif/tb_clock_gen.sv
verif/tb_channel_processor.sv

/* logic/apv_word_pkg.sv */
// Word formats of the channel back end.
// Frame field widths and the 21-bit output word that the zero suppressor
// writes into the event FIFO. The two top bits of every output word select
// how the rest is decoded: header, strip, module trailer or count trailer.
// Compile after chan_mem_pkg, whose strip address width sizes the strip field.

`default_nettype none

package apv_word_pkg;

	localparam int sample_w = 13;		// decoded frame word
	localparam int value_w = 12;		// baseline, threshold, difference
	localparam int chan_id_w = 4;
	localparam int module_id_w = 5;
	localparam int out_w = 21;
	localparam int count_w = 8;		// words per event, trailer included

	// header and module trailer are always in the event
	localparam logic [count_w-1:0] base_word_count = 8'd2;

	localparam logic [1:0] flag_header = 2'b00;
	localparam logic [1:0] flag_strip = 2'b01;
	localparam logic [1:0] flag_mod_trailer = 2'b10;
	localparam logic [1:0] flag_cnt_trailer = 2'b11;

	typedef union packed {
		struct packed {
			logic [1:0] flags;
			logic zero;
			logic base_msb;			// baseline bit 11
			logic [sample_w-1:0] frame_hdr;
			logic [chan_id_w-1:0] chan_id;
		} hdr;
		struct packed {
			logic [1:0] flags;
			logic [chan_mem_pkg::strip_addr_w-1:0] index;
			logic [value_w-1:0] diff;	// sample minus baseline
		} strip;
		struct packed {
			logic [1:0] flags;
			logic [1:0] zero;
			logic [module_id_w-1:0] module_id;
			logic [value_w-1:0] trailer;	// low bits of the frame trailer
		} mtrl;
		struct packed {
			logic [1:0] flags;
			logic [value_w-2:0] base_lo;	// baseline bits 10..0
			logic [count_w-1:0] count;
		} ctrl;
	} out_word_t;

endpackage

`default_nettype wire

/* logic/chan_mem_pkg.sv */
// Memory geometry of one readout channel.
// Sizes of the threshold RAM and the output event FIFO, the threshold value
// that masks a strip, and the width of the finished-event counter.

`default_nettype none

package chan_mem_pkg;

	localparam int strips = 128;		// strips per APV frame
	localparam int strip_addr_w = 7;

	// threshold word that switches a strip off
	localparam logic [11:0] thr_disabled = 12'hFFF;

	localparam int fifo_depth = 2048;
	localparam int fifo_addr_w = $clog2(fifo_depth);
	localparam int usedw_w = fifo_addr_w + 1;	// msb set means full

	localparam int ev_cnt_w = 5;		// saturates at 31

endpackage

`default_nettype wire

/* logic/channel_processor.sv */
// Back end of one APV25 readout channel.
// Zero suppression with baseline subtraction from a decoded frame source
// into an event FIFO that the host drains. With the channel disabled the
// host port reads back the threshold RAM in place of FIFO data.
// all_clear empties the FIFO and resets the suppressor and event count.

`timescale 1ns/10ps
`default_nettype none

module channel_processor (
	input  logic CLK,
	input  logic RSTb,
	input  logic all_clear,
	input  logic ch_enable,
	input  logic enable_base_sub,
	input  logic [apv_word_pkg::value_w-1:0] baseline,
	input  logic [apv_word_pkg::chan_id_w-1:0] channel_id,
	input  logic [apv_word_pkg::module_id_w-1:0] module_id,
	input  logic [apv_word_pkg::sample_w-1:0] frame_data,
	input  logic frame_present,
	output logic frame_rd,
	input  logic [chan_mem_pkg::strip_addr_w-1:0] ram_address,
	input  logic [apv_word_pkg::value_w-1:0] ram_data,
	input  logic ram_we,
	input  logic fifo_rd,
	output apv_word_pkg::out_word_t data_out,
	output logic [chan_mem_pkg::usedw_w-1:0] fifo_used_words,
	output logic fifo_empty,
	output logic fifo_full,
	output logic fifo_full_seen,
	output logic event_present,
	input  logic decr_event
);
	import apv_word_pkg::*;
	import chan_mem_pkg::*;

	logic [strip_addr_w-1:0] strip_addr;
	logic [value_w-1:0] thr_data;
	logic fifo_wr;
	out_word_t fifo_word;
	out_word_t fifo_q;
	logic end_of_event;

	// threshold readback is zero-extended to the word width
	assign data_out = ch_enable ? fifo_q : out_word_t'({{(out_w - value_w){1'b0}}, thr_data});

	thr_ram thr_ram0 (
		.CLK(CLK),
		.ch_enable(ch_enable),
		.ram_address(ram_address),
		.strip_addr(strip_addr),
		.ram_data(ram_data),
		.ram_we(ram_we),
		.thr_data(thr_data)
	);

	zero_suppressor zs0 (
		.CLK(CLK),
		.RSTb(RSTb),
		.clear(all_clear),
		.base_sub_en(enable_base_sub),
		.baseline(baseline),
		.chan_id(channel_id),
		.module_id(module_id),
		.frame_data(frame_data),
		.frame_present(frame_present),
		.frame_rd(frame_rd),
		.strip_addr(strip_addr),
		.thr_data(thr_data),
		.fifo_wr(fifo_wr),
		.fifo_word(fifo_word),
		.end_of_event(end_of_event)
	);

	event_fifo fifo0 (
		.CLK(CLK),
		.RSTb(RSTb),
		.clear(all_clear),
		.wr(fifo_wr),
		.wr_word(fifo_word),
		.rd(fifo_rd),
		.q(fifo_q),
		.used_words(fifo_used_words),
		.empty(fifo_empty),
		.full(fifo_full),
		.full_seen(fifo_full_seen)
	);

	event_counter ev_cnt0 (
		.CLK(CLK),
		.RSTb(RSTb),
		.clear(all_clear),
		.inc(end_of_event),
		.dec(decr_event),
		.event_present(event_present)
	);

endmodule

`default_nettype wire

/* logic/event_counter.sv */
// Count of finished events waiting in the output FIFO.
// inc comes from the suppressor at the end of each event, dec from the host
// once it has read an event out. The count saturates at both ends and
// event_present is its registered non-zero flag.

`timescale 1ns/10ps
`default_nettype none

module event_counter (
	input  logic CLK,
	input  logic RSTb,
	input  logic clear,
	input  logic inc,
	input  logic dec,
	output logic event_present
);
	import chan_mem_pkg::*;

	logic [ev_cnt_w-1:0] cnt;

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			cnt <= '0;
			event_present <= 1'b0;
		end
		else if (clear)
		begin
			cnt <= '0;
			event_present <= 1'b0;
		end
		else
		begin
			event_present <= (cnt != '0);	// one cycle behind the count
			if (inc && (cnt != '1))
				cnt <= cnt + 1'b1;
			else if (dec && (cnt != '0))
				cnt <= cnt - 1'b1;	// also taken when inc hits saturation
		end
	end

endmodule

`default_nettype wire

/* logic/event_fifo.sv */
// Output event buffer, 2048 words of 21 bits, show-ahead.
// q always shows the oldest word; rd pops it. used_words counts the stored
// words and its top bit doubles as the full flag. Writes into a full buffer
// are dropped and set full_seen, which holds until clear.

`timescale 1ns/10ps
`default_nettype none

module event_fifo (
	input  logic CLK,
	input  logic RSTb,
	input  logic clear,
	input  logic wr,
	input  apv_word_pkg::out_word_t wr_word,
	input  logic rd,
	output apv_word_pkg::out_word_t q,
	output logic [chan_mem_pkg::usedw_w-1:0] used_words,
	output logic empty,
	output logic full,
	output logic full_seen
);
	import apv_word_pkg::*;
	import chan_mem_pkg::*;

	out_word_t mem [fifo_depth];
	logic [fifo_addr_w-1:0] wr_ptr;
	logic [fifo_addr_w-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr && !full;		// lost when full
	assign do_rd = rd && !empty;

	assign empty = (used_words == '0);
	assign full = used_words[usedw_w-1];

	always_ff @(posedge CLK)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_word;
	end

	assign q = mem[rd_ptr];			// show-ahead head word

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used_words <= '0;
			full_seen <= 1'b0;
		end
		else if (clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used_words <= '0;
			full_seen <= 1'b0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;	// wraps, depth is a power of two
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: used_words <= used_words + 1'b1;
				2'b01: used_words <= used_words - 1'b1;
				default: used_words <= used_words;
			endcase
			if (wr && full)
				full_seen <= 1'b1;	// sticky overflow
		end
	end

	// the host must only pop while a word is shown
	a_no_underflow: assert property (@(posedge CLK) disable iff (!RSTb) rd |-> !empty)
		else $error("event FIFO read while empty");

endmodule

`default_nettype wire

/* logic/thr_ram.sv */
// Per-strip threshold memory, 128 words of 12 bits.
// The host writes it through ram_address. One synchronous read port is
// shared: it follows the host address while the channel is disabled, for
// readback, and the suppressor's strip index while it is enabled.

`timescale 1ns/10ps
`default_nettype none

module thr_ram (
	input  logic CLK,
	input  logic ch_enable,
	input  logic [chan_mem_pkg::strip_addr_w-1:0] ram_address,
	input  logic [chan_mem_pkg::strip_addr_w-1:0] strip_addr,
	input  logic [apv_word_pkg::value_w-1:0] ram_data,
	input  logic ram_we,
	output logic [apv_word_pkg::value_w-1:0] thr_data
);
	import apv_word_pkg::*;
	import chan_mem_pkg::*;

	logic [value_w-1:0] mem [strips];
	logic [strip_addr_w-1:0] rd_addr;

	assign rd_addr = ch_enable ? strip_addr : ram_address;	// engine owns the port when enabled

	always_ff @(posedge CLK)
	begin
		if (ram_we)
			mem[ram_address] <= ram_data;
		thr_data <= mem[rd_addr];	// valid one cycle after the address
	end

endmodule

`default_nettype wire

/* logic/zero_suppressor.sv */
// Zero suppression for one APV channel.
// Reads a decoded frame (header, 128 strips, trailer) from a show-ahead
// source, subtracts the baseline from each strip, keeps the strips above
// their threshold and formats the event for the output FIFO: header word,
// strip words, module trailer and word-count trailer.
// Each strip takes two cycles so the threshold RAM read lines up with the
// sample. end_of_event pulses once per event, just before the count trailer.

`timescale 1ns/10ps
`default_nettype none

module zero_suppressor (
	input  logic CLK,
	input  logic RSTb,
	input  logic clear,
	input  logic base_sub_en,
	input  logic [apv_word_pkg::value_w-1:0] baseline,
	input  logic [apv_word_pkg::chan_id_w-1:0] chan_id,
	input  logic [apv_word_pkg::module_id_w-1:0] module_id,
	input  logic [apv_word_pkg::sample_w-1:0] frame_data,
	input  logic frame_present,
	output logic frame_rd,
	output logic [chan_mem_pkg::strip_addr_w-1:0] strip_addr,
	input  logic [apv_word_pkg::value_w-1:0] thr_data,
	output logic fifo_wr,
	output apv_word_pkg::out_word_t fifo_word,
	output logic end_of_event
);
	import apv_word_pkg::*;
	import chan_mem_pkg::*;

	localparam logic [2:0] s_idle = 3'd0;
	localparam logic [2:0] s_wait = 3'd1;	// next sample and threshold on their way
	localparam logic [2:0] s_cut = 3'd2;
	localparam logic [2:0] s_twait = 3'd3;	// trailer on its way
	localparam logic [2:0] s_trail = 3'd4;
	localparam logic [2:0] s_eoe = 3'd5;
	localparam logic [2:0] s_count = 3'd6;

	localparam logic [strip_addr_w-1:0] last_strip = strip_addr_w'(strips - 1);

	logic [2:0] state;
	logic [value_w-1:0] sub_value;
	logic [sample_w-1:0] diff;
	logic strip_hit;
	logic [count_w-1:0] word_count;

	assign sub_value = base_sub_en ? baseline : '0;
	assign diff = frame_data - {1'b0, sub_value};		// 13-bit, wraps below zero
	assign strip_hit = (thr_data != thr_disabled) && (diff > {1'b0, thr_data});

	always_ff @(posedge CLK or negedge RSTb)
	begin
		if (!RSTb)
		begin
			state <= s_idle;
			frame_rd <= 1'b0;
			fifo_wr <= 1'b0;
			end_of_event <= 1'b0;
			strip_addr <= '0;
		end
		else if (clear)
		begin
			state <= s_idle;
			frame_rd <= 1'b0;
			fifo_wr <= 1'b0;
			end_of_event <= 1'b0;
			strip_addr <= '0;
		end
		else
		begin
			frame_rd <= 1'b0;
			fifo_wr <= 1'b0;
			end_of_event <= 1'b0;
			case (state)
				s_idle:
					if (frame_present)
					begin
						frame_rd <= 1'b1;	// pop header
						fifo_wr <= 1'b1;
						state <= s_wait;
					end
				s_wait:
					state <= s_cut;
				s_cut:
				begin
					frame_rd <= 1'b1;		// pop this strip
					fifo_wr <= strip_hit;
					strip_addr <= strip_addr + 1'b1;	// back to 0 after the last strip
					state <= (strip_addr == last_strip) ? s_twait : s_wait;
				end
				s_twait:
					state <= s_trail;
				s_trail:
				begin
					frame_rd <= 1'b1;		// pop trailer
					fifo_wr <= 1'b1;
					state <= s_eoe;
				end
				s_eoe:
				begin
					end_of_event <= 1'b1;
					state <= s_count;
				end
				s_count:
				begin
					fifo_wr <= 1'b1;
					state <= s_idle;
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	// output word and its count, loaded in the state that writes them
	always_ff @(posedge CLK)
	begin
		case (state)
			s_idle:
			begin
				word_count <= base_word_count;
				fifo_word.hdr.flags <= flag_header;
				fifo_word.hdr.zero <= 1'b0;
				fifo_word.hdr.base_msb <= baseline[value_w-1];
				fifo_word.hdr.frame_hdr <= frame_data;
				fifo_word.hdr.chan_id <= chan_id;
			end
			s_cut:
			begin
				if (strip_hit)
					word_count <= word_count + 1'b1;
				fifo_word.strip.flags <= flag_strip;
				fifo_word.strip.index <= strip_addr;
				fifo_word.strip.diff <= diff[value_w-1:0];
			end
			s_trail:
			begin
				fifo_word.mtrl.flags <= flag_mod_trailer;
				fifo_word.mtrl.zero <= 2'b00;
				fifo_word.mtrl.module_id <= module_id;
				fifo_word.mtrl.trailer <= frame_data[value_w-1:0];
			end
			s_count:
			begin
				fifo_word.ctrl.flags <= flag_cnt_trailer;
				fifo_word.ctrl.base_lo <= baseline[value_w-2:0];
				fifo_word.ctrl.count <= word_count;
			end
			default: ;
		endcase
	end

	// the frame source needs a gap between pops
	a_single_pop: assert property (@(posedge CLK) disable iff (!RSTb) frame_rd |=> !frame_rd)
		else $error("frame_rd high two cycles in a row");

	// threshold RAM must see the same address through both strip cycles
	a_addr_hold: assert property (@(posedge CLK) disable iff (!RSTb)
		(state == s_cut) |-> $stable(strip_addr))
		else $error("strip address moved during evaluation");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the channel processor testbench with Verilator and runs it.
# The log is searched for the pass line; anything else is a failure.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f flist.f --top-module tb_channel_processor -o tb_sim

./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -qx "TEST OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* verif/tb_channel_processor.sv */
// Testbench for the channel processor.
// Models the show-ahead frame source, predicts every event from the frame,
// baseline and thresholds, and drains the output FIFO against the model.
// Covers threshold readback, suppression with and without baseline
// subtraction, event counting with saturation, and FIFO overflow and clear.

`timescale 1ns/10ps
`default_nettype none

module tb_channel_processor;
	import apv_word_pkg::*;
	import chan_mem_pkg::*;

	localparam int frame_len = strips + 2;	// header, strips, trailer
	localparam int n_pairs = 8;		// each frame runs with and without subtraction
	localparam int n_count_events = 18;
	localparam int n_overflow_events = 16;
	localparam int n_events = 2 * n_pairs + n_count_events + 1 + n_overflow_events;
	localparam int cycle_limit = 300 * n_events + 2000;
	localparam int ev_max = (1 << ev_cnt_w) - 1;

	logic CLK;
	logic RSTb;
	logic all_clear;
	logic ch_enable;
	logic enable_base_sub;
	logic [value_w-1:0] baseline;
	logic [chan_id_w-1:0] channel_id;
	logic [module_id_w-1:0] module_id;
	logic [sample_w-1:0] frame_data;
	logic frame_present;
	logic frame_rd;
	logic [strip_addr_w-1:0] ram_address;
	logic [value_w-1:0] ram_data;
	logic ram_we;
	logic fifo_rd;
	out_word_t data_out;
	logic [usedw_w-1:0] fifo_used_words;
	logic fifo_empty;
	logic fifo_full;
	logic fifo_full_seen;
	logic event_present;
	logic decr_event;

	integer seed;
	int cycles;
	int ev_count;				// model of the finished-event count
	logic draining;
	string test_name;
	logic [sample_w-1:0] src_q [$];		// words waiting at the frame source
	out_word_t exp_q [$];
	logic [value_w-1:0] thr_model [strips];
	logic [sample_w-1:0] frame [frame_len];

	tb_clock_gen clk_gen0 (
		.CLK(CLK),
		.RSTb(RSTb)
	);

	channel_processor dut0 (
		.CLK(CLK),
		.RSTb(RSTb),
		.all_clear(all_clear),
		.ch_enable(ch_enable),
		.enable_base_sub(enable_base_sub),
		.baseline(baseline),
		.channel_id(channel_id),
		.module_id(module_id),
		.frame_data(frame_data),
		.frame_present(frame_present),
		.frame_rd(frame_rd),
		.ram_address(ram_address),
		.ram_data(ram_data),
		.ram_we(ram_we),
		.fifo_rd(fifo_rd),
		.data_out(data_out),
		.fifo_used_words(fifo_used_words),
		.fifo_empty(fifo_empty),
		.fifo_full(fifo_full),
		.fifo_full_seen(fifo_full_seen),
		.event_present(event_present),
		.decr_event(decr_event)
	);

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic [value_w-1:0] random_threshold();
		logic [31:0] r;
		r = rand32();
		if (r[2:0] == 3'd0)
			return thr_disabled;	// about one strip in eight masked
		return r[15:4];
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic report_mismatch(input string name, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		fail_run($sformatf("CHECK FAILED %s %s: expected %0h, actual %0h",
			name, field, expected, actual));
	endtask

	// flags first, then every field of the decoding they select
	task automatic check_word(input string name, input out_word_t expected,
			input out_word_t actual);
		if (expected.hdr.flags !== actual.hdr.flags)
			report_mismatch(name, "flags", 32'(expected.hdr.flags), 32'(actual.hdr.flags));
		case (expected.hdr.flags)
			flag_header:
			begin
				if (expected.hdr.zero !== actual.hdr.zero)
					report_mismatch(name, "header zero", 32'(expected.hdr.zero),
						32'(actual.hdr.zero));
				if (expected.hdr.base_msb !== actual.hdr.base_msb)
					report_mismatch(name, "baseline msb", 32'(expected.hdr.base_msb),
						32'(actual.hdr.base_msb));
				if (expected.hdr.frame_hdr !== actual.hdr.frame_hdr)
					report_mismatch(name, "frame header", 32'(expected.hdr.frame_hdr),
						32'(actual.hdr.frame_hdr));
				if (expected.hdr.chan_id !== actual.hdr.chan_id)
					report_mismatch(name, "channel id", 32'(expected.hdr.chan_id),
						32'(actual.hdr.chan_id));
			end
			flag_strip:
			begin
				if (expected.strip.index !== actual.strip.index)
					report_mismatch(name, "strip index", 32'(expected.strip.index),
						32'(actual.strip.index));
				if (expected.strip.diff !== actual.strip.diff)
					report_mismatch(name, "strip difference", 32'(expected.strip.diff),
						32'(actual.strip.diff));
			end
			flag_mod_trailer:
			begin
				if (expected.mtrl.zero !== actual.mtrl.zero)
					report_mismatch(name, "trailer zero", 32'(expected.mtrl.zero),
						32'(actual.mtrl.zero));
				if (expected.mtrl.module_id !== actual.mtrl.module_id)
					report_mismatch(name, "module id", 32'(expected.mtrl.module_id),
						32'(actual.mtrl.module_id));
				if (expected.mtrl.trailer !== actual.mtrl.trailer)
					report_mismatch(name, "frame trailer", 32'(expected.mtrl.trailer),
						32'(actual.mtrl.trailer));
			end
			default:
			begin
				if (expected.ctrl.base_lo !== actual.ctrl.base_lo)
					report_mismatch(name, "baseline low", 32'(expected.ctrl.base_lo),
						32'(actual.ctrl.base_lo));
				if (expected.ctrl.count !== actual.ctrl.count)
					report_mismatch(name, "word count", 32'(expected.ctrl.count),
						32'(actual.ctrl.count));
			end
		endcase
	endtask

	task automatic check_used(input string name, input logic [usedw_w-1:0] expected,
			input logic [usedw_w-1:0] actual);
		if (expected !== actual)
			report_mismatch(name, "used words", 32'(expected), 32'(actual));
	endtask

	task automatic check_flag(input string name, input string flag, input logic expected,
			input logic actual);
		if (expected !== actual)
			report_mismatch(name, flag, 32'(expected), 32'(actual));
	endtask

	task automatic update_source();
		frame_present = (src_q.size() >= frame_len);	// whole frame waiting
		frame_data = (src_q.size() > 0) ? src_q[0] : '0;
	endtask

	// one clock, then the frame source and the host side react
	task automatic next_cycle();
		out_word_t w;
		@(posedge CLK);
		#10;
		cycles++;
		if (cycles > cycle_limit)
			fail_run("timeout: the DUT stopped making progress");
		if (frame_rd)
		begin
			if (src_q.size() == 0)
				fail_run("frame_rd pulsed while the frame source was empty");
			void'(src_q.pop_front());
		end
		update_source();
		fifo_rd = 1'b0;
		if (draining && !fifo_empty)
		begin
			if (exp_q.size() == 0)
				fail_run("the output FIFO holds a word that no event predicts");
			w = exp_q.pop_front();
			check_word(test_name, w, data_out);
			fifo_rd = 1'b1;
		end
	endtask

	task automatic write_threshold(input logic [strip_addr_w-1:0] addr,
			input logic [value_w-1:0] value);
		ram_address = addr;
		ram_data = value;
		ram_we = 1'b1;
		thr_model[addr] = value;
		next_cycle();
		ram_we = 1'b0;
	endtask

	task automatic read_threshold(input logic [strip_addr_w-1:0] addr);
		out_word_t w;
		ram_address = addr;
		next_cycle();		// read data one cycle after the address
		w = '0;
		w[value_w-1:0] = thr_model[addr];
		check_word(test_name, w, data_out);
	endtask

	task automatic make_frame(input logic nonzero);
		logic [31:0] r;
		for (int i = 0; i < frame_len; i++)
		begin
			r = rand32();
			frame[i] = r[sample_w-1:0];
			if (nonzero && frame[i] == '0)
				frame[i] = 13'd1;
		end
	endtask

	task automatic randomize_event_fields();
		logic [31:0] r;
		r = rand32();
		channel_id = r[3:0];
		module_id = r[8:4];
		baseline = r[20:9];
	endtask

	// expected event: header, strips above threshold, module and count trailers
	task automatic predict_event(input logic sub_en);
		out_word_t w;
		logic [sample_w-1:0] sub;
		logic [sample_w-1:0] d;
		logic [count_w-1:0] n;
		n = base_word_count;
		sub = sub_en ? {1'b0, baseline} : '0;
		w = '0;
		w.hdr.flags = flag_header;
		w.hdr.base_msb = baseline[value_w-1];
		w.hdr.frame_hdr = frame[0];
		w.hdr.chan_id = channel_id;
		exp_q.push_back(w);
		for (int i = 0; i < strips; i++)
		begin
			d = frame[i + 1] - sub;		// wraps below zero
			if (thr_model[i] != thr_disabled && d > {1'b0, thr_model[i]})
			begin
				w = '0;
				w.strip.flags = flag_strip;
				w.strip.index = i[strip_addr_w-1:0];
				w.strip.diff = d[value_w-1:0];
				exp_q.push_back(w);
				n++;
			end
		end
		w = '0;
		w.mtrl.flags = flag_mod_trailer;
		w.mtrl.module_id = module_id;
		w.mtrl.trailer = frame[frame_len-1][value_w-1:0];
		exp_q.push_back(w);
		w = '0;
		w.ctrl.flags = flag_cnt_trailer;
		w.ctrl.base_lo = baseline[value_w-2:0];
		w.ctrl.count = n;
		exp_q.push_back(w);
	endtask

	task automatic count_event();
		if (ev_count < ev_max)
			ev_count++;
	endtask

	task automatic push_frame();
		for (int i = 0; i < frame_len; i++)
			src_q.push_back(frame[i]);
		update_source();
	endtask

	task automatic run_event(input logic sub_en);
		randomize_event_fields();
		enable_base_sub = sub_en;
		predict_event(sub_en);
		push_frame();
		while (exp_q.size() != 0)
			next_cycle();		// count trailer drained ends the event
		count_event();
		check_flag(test_name, "event_present", ev_count != 0, event_present);
	endtask

	task automatic pulse_decrement();
		decr_event = 1'b1;
		if (ev_count > 0)
			ev_count--;
		next_cycle();
		decr_event = 1'b0;
		next_cycle();		// flag trails the count by a cycle
		check_flag(test_name, "event_present", ev_count != 0, event_present);
	endtask

	initial
	begin
		logic [31:0] r;
		seed = 32'h253e;
		cycles = 0;
		ev_count = 0;
		draining = 1'b0;
		test_name = "reset";
		all_clear = 1'b0;
		ch_enable = 1'b0;
		enable_base_sub = 1'b0;
		baseline = '0;
		channel_id = '0;
		module_id = '0;
		frame_data = '0;
		frame_present = 1'b0;
		ram_address = '0;
		ram_data = '0;
		ram_we = 1'b0;
		fifo_rd = 1'b0;
		decr_event = 1'b0;
		wait (RSTb === 1'b1);
		next_cycle();
		check_flag(test_name, "fifo_empty", 1'b1, fifo_empty);
		check_flag(test_name, "event_present", 1'b0, event_present);
		check_flag(test_name, "fifo_full_seen", 1'b0, fifo_full_seen);
		check_flag(test_name, "frame_rd", 1'b0, frame_rd);

		test_name = "threshold readback";
		for (int a = 0; a < strips; a++)
			write_threshold(a[strip_addr_w-1:0], random_threshold());
		for (int k = 0; k < 64; k++)
		begin
			r = rand32();
			write_threshold(r[strip_addr_w-1:0], random_threshold());
		end
		for (int a = 0; a < strips; a++)
			read_threshold(a[strip_addr_w-1:0]);

		ch_enable = 1'b1;
		draining = 1'b1;
		for (int e = 0; e < n_pairs; e++)
		begin
			make_frame(1'b0);
			test_name = "subtraction on";
			run_event(1'b1);
			test_name = "subtraction off";
			run_event(1'b0);
		end

		test_name = "event count";
		for (int e = 0; e < n_count_events; e++)
		begin
			make_frame(1'b0);
			run_event(rand32() % 2 == 0);
		end
		for (int k = 0; k < ev_max + 4; k++)
			pulse_decrement();	// runs past zero
		make_frame(1'b0);
		run_event(1'b1);
		pulse_decrement();

		test_name = "overflow";
		draining = 1'b0;
		for (int a = 0; a < strips; a++)
			write_threshold(a[strip_addr_w-1:0], '0);
		randomize_event_fields();
		enable_base_sub = 1'b0;
		for (int e = 0; e < n_overflow_events; e++)
		begin
			make_frame(1'b1);	// every strip above threshold 0
			push_frame();
			count_event();
		end
		while (src_q.size() != 0)
			next_cycle();
		repeat (4) next_cycle();	// last trailers and the count settle
		check_flag(test_name, "fifo_full", 1'b1, fifo_full);
		check_flag(test_name, "fifo_full_seen", 1'b1, fifo_full_seen);
		check_used(test_name, usedw_w'(fifo_depth), fifo_used_words);
		check_flag(test_name, "event_present", 1'b1, event_present);

		test_name = "clear";
		all_clear = 1'b1;
		next_cycle();
		all_clear = 1'b0;
		ev_count = 0;
		check_flag(test_name, "fifo_empty", 1'b1, fifo_empty);
		check_used(test_name, '0, fifo_used_words);
		check_flag(test_name, "event_present", 1'b0, event_present);
		check_flag(test_name, "fifo_full_seen", 1'b0, fifo_full_seen);

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// Clock and reset source for the channel processor testbench.
// Free-running 100 ns clock. Reset is held low for five rising edges and
// released a little after the last one, in step with the other stimulus.

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic CLK,
	output logic RSTb
);
	localparam int period_ns = 100;
	localparam int reset_cycles = 5;
	localparam int drive_delay_ns = 10;

	initial
	begin
		CLK = 1'b0;
		forever #(period_ns / 2) CLK = ~CLK;
	end

	initial
	begin
		RSTb = 1'b0;
		repeat (reset_cycles) @(posedge CLK);
		#(drive_delay_ns) RSTb = 1'b1;	// released off the edge
	end

endmodule

`default_nettype wire
